/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal
TOP       := tb_noc_mesh
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim.f */
verilog/noc_pkg.sv
verilog/flit_fifo.sv
verilog/input_unit.sv
verilog/output_arbiter.sv
verilog/noc_router.sv
verilog/noc_mesh.sv
tests/clk_gen.sv
tests/tb_noc_mesh.sv

/* tests/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a rising edge, as the DUT reset is synchronous
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tests/tb_noc_mesh.sv */
`timescale 1ns/100ps

module tb_noc_mesh
    import noc_pkg::*;
();

    localparam int MESH_ROWS   = 2;
    localparam int MESH_COLS   = 2;
    localparam int FIFO_DEPTH  = FIFO_DEPTH_DEFAULT;
    localparam int NODES       = MESH_ROWS * MESH_COLS;
    localparam int SRC_W       = $clog2(NODES);
    localparam int IDX_W       = 2;
    localparam int SEQ_W       = DATA_W - 2 * SRC_W - IDX_W;
    localparam int FLIT_W      = 1 + ADDR_W + DATA_W;    // {tail, dest, data}
    localparam int MAX_LEN     = 4;
    localparam int RAND_PKTS   = 60;
    localparam int BP_NODE     = 2;
    localparam int BP_HOLD     = 60;
    localparam int TOTAL_FLITS = NODES * 2 * FIFO_DEPTH + NODES * NODES + 2 * MAX_LEN
                               + (NODES - 1) * 2 * MAX_LEN + 1 + RAND_PKTS * MAX_LEN;
    localparam int CYCLE_LIMIT = 40 * TOTAL_FLITS + 200;

    logic                         clk;
    logic                         rst_n;
    logic [NODES-1:0]             inj_send = '0;
    logic [NODES-1:0][DATA_W-1:0] inj_data = '0;
    logic [NODES-1:0][ADDR_W-1:0] inj_dest = '0;
    logic [NODES-1:0]             inj_tail = '0;
    logic [NODES-1:0]             inj_credit;
    logic [NODES-1:0]             ej_send;
    logic [NODES-1:0][DATA_W-1:0] ej_data;
    logic [NODES-1:0]             ej_tail;
    logic [NODES-1:0]             ej_credit = '0;

    int                seed = 60659;
    int                cycles = 0;
    logic [FLIT_W-1:0] inj_q [NODES][$];            // Flits waiting to be injected
    logic [DATA_W:0]   exp_q [NODES * NODES][$];    // {tail, data} per source-destination pair
    int                seq_cnt [NODES * NODES];
    int                inj_cred [NODES];
    int                injected [NODES];
    int                credits_back [NODES];
    int                burst_sent [NODES];          // Sends before any credit came back
    int                received [NODES];
    int                granted [NODES];
    int                pending [NODES];             // Ejected flits not yet credited
    int                cur_src [NODES];
    logic [NODES-1:0]  in_packet = '0;
    logic [NODES-1:0]  hold = '0;
    logic              rand_credit = 1'b0;

    clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (8)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    noc_mesh #(
        .MESH_ROWS  (MESH_ROWS),
        .MESH_COLS  (MESH_COLS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inj_send   (inj_send),
        .inj_data   (inj_data),
        .inj_dest   (inj_dest),
        .inj_tail   (inj_tail),
        .inj_credit (inj_credit),
        .ej_send    (ej_send),
        .ej_data    (ej_data),
        .ej_tail    (ej_tail),
        .ej_credit  (ej_credit)
    );

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Data word is {src, dst, seq, idx}
    function automatic logic [DATA_W-1:0] expected_flit(input int src, input int dst,
                                                        input int seq, input int idx);
        return DATA_W'((src << (DATA_W - SRC_W)) | (dst << (DATA_W - 2 * SRC_W))
                       | ((seq % (1 << SEQ_W)) << IDX_W) | idx);
    endfunction

    function automatic logic [ADDR_W-1:0] node_addr(input int n);
        return ADDR_W'(((n / MESH_COLS) << COL_W) | (n % MESH_COLS));    // {row, col}
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic queue_packet(input int src, input int dst, input int len);
        logic [DATA_W-1:0] d;
        logic              t;
        int                pair;
        pair = src * NODES + dst;
        for (int i = 0; i < len; i++) begin
            d = expected_flit(src, dst, seq_cnt[pair], i);
            t = (i == len - 1);
            inj_q[src].push_back({t, node_addr(dst), d});
            exp_q[pair].push_back({t, d});
        end
        seq_cnt[pair]++;
    endtask

    function automatic logic mesh_idle();
        for (int n = 0; n < NODES; n++) begin
            if (inj_q[n].size() != 0 || pending[n] != 0)
                return 1'b0;
        end
        for (int p = 0; p < NODES * NODES; p++) begin
            if (exp_q[p].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_drain();
        while (!mesh_idle()) @(negedge clk);
        repeat (4) @(negedge clk);    // Last credits settle on both sides
    endtask

    // --------------------------------------------------
    // Inject side, one flit per credit
    // --------------------------------------------------
    always @(posedge clk) begin
        logic [FLIT_W-1:0] f;
        for (int n = 0; n < NODES; n++) begin
            if (!rst_n) begin
                inj_cred[n]     = FIFO_DEPTH;
                injected[n]     = 0;
                credits_back[n] = 0;
                burst_sent[n]   = 0;
                inj_send[n]    <= 1'b0;
            end else begin
                if (inj_credit[n]) begin
                    inj_cred[n]++;
                    credits_back[n]++;
                end
                if (inj_q[n].size() > 0 && inj_cred[n] > 0) begin
                    f = inj_q[n].pop_front();
                    {inj_tail[n], inj_dest[n], inj_data[n]} <= f;
                    inj_send[n] <= 1'b1;
                    inj_cred[n]--;
                    injected[n]++;
                    if (credits_back[n] == 0) burst_sent[n]++;
                end else begin
                    inj_send[n] <= 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------
    // Eject side, compare and credit return
    // --------------------------------------------------
    always @(posedge clk) begin
        logic [DATA_W:0] exp;
        int              src;
        int              pair;
        for (int n = 0; n < NODES; n++) begin
            if (!rst_n) begin
                received[n]   = 0;
                granted[n]    = 0;
                pending[n]    = 0;
                cur_src[n]    = 0;
                in_packet[n]  = 1'b0;
                ej_credit[n] <= 1'b0;
            end else begin
                if (ej_send[n]) begin
                    src  = int'(ej_data[n][DATA_W-1 -: SRC_W]);
                    pair = src * NODES + n;
                    check_value(received[n] < FIFO_DEPTH + granted[n], 1,
                                "eject send beyond granted credits");
                    check_value(exp_q[pair].size() != 0, 1, "flit at eject port with none due");
                    if (in_packet[n]) check_value(src, cur_src[n], "packets interleaved");
                    exp = exp_q[pair].pop_front();
                    check_value({ej_tail[n], ej_data[n]}, exp, "ejected flit");
                    in_packet[n] = !ej_tail[n];
                    cur_src[n]   = src;
                    received[n]++;
                    pending[n]++;
                end
                // Random delay in credit return when enabled
                if (pending[n] > 0 && !hold[n] && (!rand_credit || ($random(seed) & 3) == 0)) begin
                    ej_credit[n] <= 1'b1;
                    pending[n]--;
                    granted[n]++;
                end else begin
                    ej_credit[n] <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int base;
        int src;
        int dst;
        int len;
        for (int p = 0; p < NODES * NODES; p++) seq_cnt[p] = 0;
        @(posedge rst_n);
        @(negedge clk);

        // Quiet mesh after reset
        repeat (20) begin
            check_value(ej_send, 0, "ej_send active with no traffic");
            check_value(inj_credit, 0, "inj_credit active with no traffic");
            @(negedge clk);
        end
        for (int n = 0; n < NODES; n++) begin
            for (int i = 0; i < 2 * FIFO_DEPTH; i++) queue_packet(n, n, 1);
        end
        wait_drain();
        for (int n = 0; n < NODES; n++)
            check_value(burst_sent[n], FIFO_DEPTH, "flits injected before first credit");

        // Every node to every node
        for (int s = 0; s < NODES; s++) begin
            for (int d = 0; d < NODES; d++) queue_packet(s, d, 1);
        end
        wait_drain();

        queue_packet(0, 1, MAX_LEN);    // Meet at node 1 from West and South
        queue_packet(3, 1, MAX_LEN);
        wait_drain();

        // Back-pressure at one eject port
        hold[BP_NODE] = 1'b1;
        base = received[BP_NODE];
        for (int s = 0; s < NODES; s++) begin
            if (s != BP_NODE) begin
                queue_packet(s, BP_NODE, MAX_LEN);
                queue_packet(s, BP_NODE, MAX_LEN);
            end
        end
        queue_packet(BP_NODE, BP_NODE, 1);
        repeat (BP_HOLD) @(negedge clk);
        check_value(received[BP_NODE] - base, FIFO_DEPTH, "flits ejected while credits held");
        hold[BP_NODE] = 1'b0;
        wait_drain();

        // Random traffic
        for (int k = 0; k < RAND_PKTS; k++) begin
            src = int'(($random(seed) & 32'h7fff_ffff) % NODES);
            dst = int'(($random(seed) & 32'h7fff_ffff) % NODES);
            len = 1 + int'(($random(seed) & 32'h7fff_ffff) % MAX_LEN);
            queue_packet(src, dst, len);
        end
        rand_credit = 1'b1;
        wait_drain();

        for (int n = 0; n < NODES; n++)
            check_value(credits_back[n], injected[n], "credits returned at inject port");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog/flit_fifo.sv */
`timescale 1ns/100ps

module flit_fifo
    import noc_pkg::*;
#(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic [DATA_W-1:0] push_data,
    input  logic [ADDR_W-1:0] push_dest,
    input  logic              push_tail,
    input  logic              pop,
    output logic [DATA_W-1:0] head_data,
    output logic [ADDR_W-1:0] head_dest,
    output logic              head_tail,
    output logic              empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [DATA_W-1:0]   data_mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]   dest_mem [FIFO_DEPTH];
    logic                tail_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            dest_mem[wr_ptr] <= push_dest;
            tail_mem[wr_ptr] <= push_tail;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            count <= count + CREDIT_W'(push) - CREDIT_W'(pop);
        end
    end

    assign head_data = data_mem[rd_ptr];
    assign head_dest = dest_mem[rd_ptr];
    assign head_tail = tail_mem[rd_ptr];
    assign empty     = (count == '0);    // Written flit visible one cycle later

endmodule

/* verilog/input_unit.sv */
`timescale 1ns/100ps

module input_unit
    import noc_pkg::*;
#(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [ADDR_W-1:0]    my_addr,
    input  logic                 send,
    input  logic [DATA_W-1:0]    data,
    input  logic [ADDR_W-1:0]    dest,
    input  logic                 tail,
    input  logic [NUM_PORTS-1:0] grant,     // One bit per output arbiter
    input  logic                 pop,
    output logic                 credit,
    output logic [NUM_PORTS-1:0] req,
    output logic [DATA_W-1:0]    head_data,
    output logic [ADDR_W-1:0]    head_dest,
    output logic                 head_tail
);

    logic             empty;
    logic             route_valid;
    port_dir_t        route_reg;
    port_dir_t        route_calc;
    port_dir_t        route;
    logic [ROW_W-1:0] my_row;
    logic [ROW_W-1:0] dest_row;
    logic [COL_W-1:0] my_col;
    logic [COL_W-1:0] dest_col;

    flit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (send),
        .push_data (data),
        .push_dest (dest),
        .push_tail (tail),
        .pop       (pop),
        .head_data (head_data),
        .head_dest (head_dest),
        .head_tail (head_tail),
        .empty     (empty)
    );

    assign {my_row, my_col}     = my_addr;
    assign {dest_row, dest_col} = head_dest;

    // Dimension order: columns first, then rows
    always_comb begin
        if (dest_col > my_col)      route_calc = EAST;
        else if (dest_col < my_col) route_calc = WEST;
        else if (dest_row > my_row) route_calc = SOUTH;
        else if (dest_row < my_row) route_calc = NORTH;
        else                        route_calc = LOCAL;
    end

    // Route is taken from the head flit and held for the whole packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_valid <= 1'b0;
            route_reg   <= LOCAL;
        end else if (|(grant & req) && head_tail) begin
            route_valid <= 1'b0;
        end else if (!route_valid && !empty) begin
            route_valid <= 1'b1;
            route_reg   <= route_calc;
        end
    end

    assign route = route_valid ? route_reg : route_calc;

    always_comb begin
        req = '0;
        if (!empty) req[route] = 1'b1;
    end

    // One credit back upstream per popped flit
    always_ff @(posedge clk) begin
        if (!rst_n) credit <= 1'b0;
        else        credit <= pop;
    end

endmodule

/* verilog/noc_mesh.sv */
`timescale 1ns/100ps

module noc_mesh
    import noc_pkg::*;
#(
    parameter int MESH_ROWS  = MESH_ROWS_DEFAULT,
    parameter int MESH_COLS  = MESH_COLS_DEFAULT,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT,
    localparam int NODES     = MESH_ROWS * MESH_COLS
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // --------------------------------------------------
    // Inject side, node = row * MESH_COLS + col
    // --------------------------------------------------
    input  logic [NODES-1:0]             inj_send,
    input  logic [NODES-1:0][DATA_W-1:0] inj_data,
    input  logic [NODES-1:0][ADDR_W-1:0] inj_dest,
    input  logic [NODES-1:0]             inj_tail,
    output logic [NODES-1:0]             inj_credit,

    // --------------------------------------------------
    // Eject side
    // --------------------------------------------------
    output logic [NODES-1:0]             ej_send,
    output logic [NODES-1:0][DATA_W-1:0] ej_data,
    output logic [NODES-1:0]             ej_tail,
    input  logic [NODES-1:0]             ej_credit
);

    wire [NODES-1:0][NUM_PORTS-1:0]             rt_in_send;
    wire [NODES-1:0][NUM_PORTS-1:0][DATA_W-1:0] rt_in_data;
    wire [NODES-1:0][NUM_PORTS-1:0][ADDR_W-1:0] rt_in_dest;
    wire [NODES-1:0][NUM_PORTS-1:0]             rt_in_tail;
    wire [NODES-1:0][NUM_PORTS-1:0]             rt_in_credit;
    wire [NODES-1:0][NUM_PORTS-1:0]             rt_out_send;
    wire [NODES-1:0][NUM_PORTS-1:0][DATA_W-1:0] rt_out_data;
    wire [NODES-1:0][NUM_PORTS-1:0][ADDR_W-1:0] rt_out_dest;
    wire [NODES-1:0][NUM_PORTS-1:0]             rt_out_tail;
    wire [NODES-1:0][NUM_PORTS-1:0]             rt_out_credit;

    for (genvar r = 0; r < MESH_ROWS; r++) begin : g_row
        for (genvar c = 0; c < MESH_COLS; c++) begin : g_col
            localparam int               N   = r * MESH_COLS + c;
            localparam logic [ROW_W-1:0] ROW = ROW_W'(r);
            localparam logic [COL_W-1:0] COL = COL_W'(c);

            noc_router #(
                .MESH_ROWS  (MESH_ROWS),
                .MESH_COLS  (MESH_COLS),
                .FIFO_DEPTH (FIFO_DEPTH)
            ) u_router (
                .clk           (clk),
                .rst_n         (rst_n),
                .my_addr       ({ROW, COL}),
                .in_send       (rt_in_send[N]),
                .in_data       (rt_in_data[N]),
                .in_dest       (rt_in_dest[N]),
                .in_tail       (rt_in_tail[N]),
                .out_credit_in (rt_out_credit[N]),
                .in_credit     (rt_in_credit[N]),
                .out_send      (rt_out_send[N]),
                .out_data      (rt_out_data[N]),
                .out_dest      (rt_out_dest[N]),
                .out_tail      (rt_out_tail[N])
            );

            // Local port straight to the top level
            assign rt_in_send[N][LOCAL]    = inj_send[N];
            assign rt_in_data[N][LOCAL]    = inj_data[N];
            assign rt_in_dest[N][LOCAL]    = inj_dest[N];
            assign rt_in_tail[N][LOCAL]    = inj_tail[N];
            assign inj_credit[N]           = rt_in_credit[N][LOCAL];
            assign ej_send[N]              = rt_out_send[N][LOCAL];
            assign ej_data[N]              = rt_out_data[N][LOCAL];
            assign ej_tail[N]              = rt_out_tail[N][LOCAL];
            assign rt_out_credit[N][LOCAL] = ej_credit[N];

            // Neighbor links, seen from the receiving router
            for (genvar d = 1; d < NUM_PORTS; d++) begin : g_link
                localparam int NR  = (d == int'(SOUTH)) ? r + 1 :
                                     (d == int'(NORTH)) ? r - 1 : r;
                localparam int NC  = (d == int'(EAST))  ? c + 1 :
                                     (d == int'(WEST))  ? c - 1 : c;
                localparam int OPP = (d == int'(NORTH)) ? int'(SOUTH) :
                                     (d == int'(SOUTH)) ? int'(NORTH) :
                                     (d == int'(EAST))  ? int'(WEST)  : int'(EAST);

                if (NR >= 0 && NR < MESH_ROWS && NC >= 0 && NC < MESH_COLS) begin : g_nb
                    localparam int M = NR * MESH_COLS + NC;
                    assign rt_in_send[N][d]    = rt_out_send[M][OPP];
                    assign rt_in_data[N][d]    = rt_out_data[M][OPP];
                    assign rt_in_dest[N][d]    = rt_out_dest[M][OPP];
                    assign rt_in_tail[N][d]    = rt_out_tail[M][OPP];
                    assign rt_out_credit[N][d] = rt_in_credit[M][OPP];
                end else begin : g_edge
                    assign rt_in_send[N][d]    = 1'b0;
                    assign rt_in_data[N][d]    = '0;
                    assign rt_in_dest[N][d]    = '0;
                    assign rt_in_tail[N][d]    = 1'b0;
                    assign rt_out_credit[N][d] = 1'b0;    // No credit ever returns
                end
            end
        end
    end

endmodule

/* verilog/noc_pkg.sv */
package noc_pkg;

    // --------------------------------------------------
    // Mesh and flit sizes
    // --------------------------------------------------
    localparam int MESH_ROWS_DEFAULT  = 2;
    localparam int MESH_COLS_DEFAULT  = 2;
    localparam int NUM_PORTS          = 5;
    localparam int DATA_W             = 16;

    localparam int ROW_W  = (MESH_ROWS_DEFAULT > 1) ? $clog2(MESH_ROWS_DEFAULT) : 1;
    localparam int COL_W  = (MESH_COLS_DEFAULT > 1) ? $clog2(MESH_COLS_DEFAULT) : 1;
    localparam int ADDR_W = ROW_W + COL_W;    // Packed as {row, col}

    // Input buffer depth and the matching credit range
    localparam int FIFO_DEPTH_DEFAULT = 4;
    localparam int CREDIT_W           = $clog2(FIFO_DEPTH_DEFAULT + 1);

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,    // Toward row - 1
        SOUTH = 3'd2,    // Toward row + 1
        EAST  = 3'd3,    // Toward col + 1
        WEST  = 3'd4     // Toward col - 1
    } port_dir_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_t;

endpackage

/* verilog/noc_router.sv */
`timescale 1ns/100ps

module noc_router
    import noc_pkg::*;
#(
    parameter int MESH_ROWS  = MESH_ROWS_DEFAULT,
    parameter int MESH_COLS  = MESH_COLS_DEFAULT,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [ADDR_W-1:0]                my_addr,
    input  logic [NUM_PORTS-1:0]             in_send,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] in_data,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0] in_dest,
    input  logic [NUM_PORTS-1:0]             in_tail,
    input  logic [NUM_PORTS-1:0]             out_credit_in,
    output logic [NUM_PORTS-1:0]             in_credit,
    output logic [NUM_PORTS-1:0]             out_send,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] out_data,
    output logic [NUM_PORTS-1:0][ADDR_W-1:0] out_dest,
    output logic [NUM_PORTS-1:0]             out_tail
);

    // iu_* are [input][output], arb_* are [output][input]
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] iu_req;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] iu_grant;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] arb_req;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] arb_grant;
    logic [NUM_PORTS-1:0]                pop;
    logic [NUM_PORTS-1:0]                port_exists;
    logic [NUM_PORTS-1:0][DATA_W-1:0]    head_data;
    logic [NUM_PORTS-1:0][ADDR_W-1:0]    head_dest;
    logic [NUM_PORTS-1:0]                head_tail;
    logic [ROW_W-1:0]                    my_row;
    logic [COL_W-1:0]                    my_col;

    assign {my_row, my_col} = my_addr;

    // Ports facing off the mesh edge never get a request
    always_comb begin
        port_exists        = '1;
        port_exists[NORTH] = (my_row != '0);
        port_exists[SOUTH] = (int'(my_row) != MESH_ROWS - 1);
        port_exists[WEST]  = (my_col != '0);
        port_exists[EAST]  = (int'(my_col) != MESH_COLS - 1);
    end

    // --------------------------------------------------
    // Crossbar control
    // --------------------------------------------------
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                arb_req[o][i]  = iu_req[i][o] & port_exists[o];
                iu_grant[i][o] = arb_grant[o][i];
            end
        end
    end

    for (genvar gi = 0; gi < NUM_PORTS; gi++) begin : g_input
        assign pop[gi] = |iu_grant[gi];

        input_unit #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_input (
            .clk       (clk),
            .rst_n     (rst_n),
            .my_addr   (my_addr),
            .send      (in_send[gi]),
            .data      (in_data[gi]),
            .dest      (in_dest[gi]),
            .tail      (in_tail[gi]),
            .grant     (iu_grant[gi]),
            .pop       (pop[gi]),
            .credit    (in_credit[gi]),
            .req       (iu_req[gi]),
            .head_data (head_data[gi]),
            .head_dest (head_dest[gi]),
            .head_tail (head_tail[gi])
        );
    end

    // Each arbiter sees every head flit and muxes its owner's
    for (genvar go = 0; go < NUM_PORTS; go++) begin : g_output
        output_arbiter #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_arb (
            .clk       (clk),
            .rst_n     (rst_n),
            .req       (arb_req[go]),
            .head_data (head_data),
            .head_dest (head_dest),
            .head_tail (head_tail),
            .credit_in (out_credit_in[go]),
            .grant     (arb_grant[go]),
            .send      (out_send[go]),
            .data      (out_data[go]),
            .dest      (out_dest[go]),
            .tail      (out_tail[go])
        );
    end

endmodule

/* verilog/output_arbiter.sv */
`timescale 1ns/100ps

module output_arbiter
    import noc_pkg::*;
#(
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [NUM_PORTS-1:0]             req,
    input  logic [NUM_PORTS-1:0][DATA_W-1:0] head_data,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0] head_dest,
    input  logic [NUM_PORTS-1:0]             head_tail,
    input  logic                             credit_in,
    output logic [NUM_PORTS-1:0]             grant,
    output logic                             send,
    output logic [DATA_W-1:0]                data,
    output logic [ADDR_W-1:0]                dest,
    output logic                             tail
);

    arb_state_t          state;
    port_dir_t           owner;       // Input holding the lock
    port_dir_t           last_win;
    port_dir_t           pick;
    logic                pick_valid;
    logic                fwd;
    logic [CREDIT_W-1:0] credits;     // Free slots downstream

    // Round robin starting just after the last winner
    always_comb begin
        int idx;
        pick       = LOCAL;
        pick_valid = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(last_win) + k) % NUM_PORTS;
            if (!pick_valid && req[idx]) begin
                pick       = port_dir_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Move one flit when the owner has one and there is room downstream
    assign fwd = (state == ARB_LOCKED) && req[owner] && (credits != '0);

    always_comb begin
        grant        = '0;
        grant[owner] = fwd;    // Doubles as the pop of that input
    end

    // --------------------------------------------------
    // Packet lock
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            owner    <= LOCAL;
            last_win <= WEST;    // LOCAL goes first after reset
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        state    <= ARB_LOCKED;
                        owner    <= pick;
                        last_win <= pick;
                    end
                end
                ARB_LOCKED: begin
                    if (fwd && head_tail[owner]) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Credit counter and registered link
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
            send    <= 1'b0;
        end else begin
            credits <= credits - CREDIT_W'(fwd) + CREDIT_W'(credit_in);
            send    <= fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            data <= head_data[owner];
            dest <= head_dest[owner];
            tail <= head_tail[owner];
        end
    end

endmodule
